// File: bsr_scheduler.f
rtl/bsr_pkg.sv
rtl/bsr_cfg_regs.sv
rtl/bsr_row_walker.sv
rtl/bsr_block_loader.sv
rtl/bsr_scheduler.sv
verification/bsr_scheduler_assert.sv
verification/tb_bsr_scheduler.sv

// File: rtl/bsr_block_loader.sv
`timescale 1ns/1ps

module bsr_block_loader #(
    parameter int BLOCK_BYTES = 64
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_start,     // Byte 0 requested in this cycle
    input  bsr_pkg::block_idx_t      load_idx,
    output logic                     block_rd_en,
    output bsr_pkg::byte_addr_t      block_rd_addr,
    input  bsr_pkg::byte_t           block_rd_data,  // One cycle after block_rd_en
    output logic                     load_done,      // Buffer complete
    output logic [BLOCK_BYTES*8-1:0] blk_data        // Byte 0 in the lowest slot
);
    import bsr_pkg::*;

    localparam int               CNT_W  = $clog2(BLOCK_BYTES);
    localparam byte_addr_t       STRIDE = byte_addr_t'(BLOCK_BYTES);
    localparam logic [CNT_W-1:0] LAST   = CNT_W'(BLOCK_BYTES - 1);

    logic             active;       // Bytes 1 and up still to request
    logic [CNT_W-1:0] cnt;          // Slot requested this cycle, zero when idle
    byte_addr_t       start_addr;
    byte_addr_t       base;         // Address of byte 0, held for the burst
    logic             cap_en;       // A byte returns this cycle
    logic [CNT_W-1:0] cap_slot;     // Slot of that byte

    assign start_addr    = byte_addr_t'(load_idx) * STRIDE;
    assign block_rd_en   = load_start | active;
    assign block_rd_addr = (active ? base : start_addr) + byte_addr_t'(cnt);

    // Request side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (load_start) begin
            active <= 1'b1;
            cnt    <= CNT_W'(1);
        end else if (active) begin
            active <= (cnt != LAST);
            cnt    <= (cnt == LAST) ? '0 : cnt + CNT_W'(1);    // Wrap back to slot 0
        end
    end

    always_ff @(posedge clk) if (load_start) base <= start_addr;

    // Capture side, one cycle behind the requests
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_en    <= 1'b0;
            cap_slot  <= '0;
            load_done <= 1'b0;
        end else begin
            cap_en    <= block_rd_en;
            cap_slot  <= cnt;
            load_done <= cap_en && (cap_slot == LAST);  // Last byte written this edge
        end
    end

    always_ff @(posedge clk) if (cap_en) blk_data[cap_slot*8 +: 8] <= block_rd_data;

endmodule

// File: rtl/bsr_cfg_regs.sv
`timescale 1ns/1ps

module bsr_cfg_regs (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cfg_write,          // One-cycle write strobe
    input  bsr_pkg::geom_t  cfg_geom,
    input  logic            busy,               // Walker is inside a run
    input  logic            start_run,          // Run accepted this cycle
    input  logic            blk_retired,        // Systolic array finished a block
    output bsr_pkg::geom_t  geom,
    output bsr_pkg::count_t blocks_processed
);

    // ==================================================
    // Layer geometry
    // ==================================================
    // Writes land only between runs so a run sees one geometry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            geom <= '0;
        end else if (cfg_write && !busy) begin
            geom <= cfg_geom;                   // Latch new layer shape
        end
    end

    // ==================================================
    // Processed-block counter
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blocks_processed <= '0;
        end else if (start_run) begin
            blocks_processed <= '0;             // Fresh count per run
        end else if (blk_retired) begin
            blocks_processed <= blocks_processed + 32'd1;
        end
    end

    // Counter only moves inside a run, start_run wins on a collision

endmodule

// File: rtl/bsr_pkg.sv
package bsr_pkg;

    // ==================================================
    // Widths with a meaning
    // ==================================================
    typedef logic [15:0] block_row_t;   // Block row number
    typedef logic [15:0] block_col_t;   // Block column number
    typedef logic [15:0] block_idx_t;   // Global non-zero block index, also a row_ptr value
    typedef logic [15:0] meta_addr_t;   // Word address into row_ptr or col_idx
    typedef logic [23:0] byte_addr_t;   // Byte address in block memory
    typedef logic [7:0]  byte_t;        // One INT8 weight
    typedef logic [31:0] count_t;       // Performance counter

    // Which metadata array a request targets
    typedef enum logic [1:0] {
        META_ROW_PTR = 2'd0,
        META_COL_IDX = 2'd1
    } meta_kind_t;

    // ==================================================
    // Descriptors
    // ==================================================

    // Metadata read request, data returns one cycle after en
    typedef struct packed {
        logic       en;
        meta_kind_t kind;
        meta_addr_t addr;
    } meta_req_t;

    // Position of one block handed to the systolic array
    typedef struct packed {
        block_row_t row;
        block_col_t col;
        block_idx_t idx;    // Also selects the bytes in block memory
    } blk_desc_t;

    // Layer geometry in blocks
    typedef struct packed {
        block_row_t num_rows;
        block_col_t num_cols;
    } geom_t;

endpackage

// File: rtl/bsr_row_walker.sv
`timescale 1ns/1ps

module bsr_row_walker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,              // Ignored unless idle
    input  bsr_pkg::geom_t      geom,
    output bsr_pkg::meta_req_t  meta_req,
    input  logic [31:0]         meta_rd_data,       // Valid one cycle after meta_req.en
    output logic                load_start,
    output bsr_pkg::block_idx_t load_idx,
    input  logic                load_done,
    output logic                blk_valid,
    output bsr_pkg::blk_desc_t  blk_desc,
    input  logic                systolic_ready,
    input  logic                systolic_done,
    output logic                blk_retired,
    output logic                start_run,
    output logic                busy,
    output logic                done
);
    import bsr_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        ROW_LO,         // Request row_ptr[r]
        ROW_HI,         // Capture row_ptr[r], request row_ptr[r+1]
        CHECK_ROW,      // Capture row_ptr[r+1], skip if empty
        COL_REQ,        // Request col_idx[idx]
        COL_CAP,        // Capture column, kick the loader
        LOAD,
        OFFER,          // blk_valid held until systolic_ready
        WAIT_DONE,      // Wait for systolic_done
        NEXT_BLOCK,
        NEXT_ROW,
        FINISH
    } walk_state_t;

    walk_state_t state;
    walk_state_t state_nxt;

    block_row_t cur_row;
    block_idx_t cur_idx;
    block_idx_t row_lo;     // First block of the row
    block_idx_t row_hi;     // First block of the next row
    block_col_t cur_col;

    logic last_row;
    logic row_empty;
    logic last_blk;

    // 17-bit compare also covers a zero-row layer
    assign last_row  = ({1'b0, cur_row} + 17'd1) >= {1'b0, geom.num_rows};
    assign row_empty = (meta_rd_data[15:0] == row_lo);     // row_ptr[r+1] on the bus now
    assign last_blk  = ((cur_idx + 16'd1) == row_hi);

    // ==================================================
    // Next state
    // ==================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:       if (start) state_nxt = (geom.num_rows == '0) ? NEXT_ROW : ROW_LO;
            ROW_LO:     state_nxt = ROW_HI;
            ROW_HI:     state_nxt = CHECK_ROW;
            CHECK_ROW:  state_nxt = row_empty ? NEXT_ROW : COL_REQ;
            COL_REQ:    state_nxt = COL_CAP;
            COL_CAP:    state_nxt = LOAD;
            LOAD:       if (load_done) state_nxt = OFFER;
            OFFER:      if (systolic_ready) state_nxt = WAIT_DONE;    // Transfer cycle
            WAIT_DONE:  if (systolic_done) state_nxt = NEXT_BLOCK;
            NEXT_BLOCK: state_nxt = last_blk ? NEXT_ROW : COL_REQ;
            NEXT_ROW:   state_nxt = last_row ? FINISH : ROW_LO;
            FINISH:     state_nxt = IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    // ==================================================
    // Control registers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            cur_row <= '0;
            cur_idx <= '0;
        end else begin
            state <= state_nxt;
            if (state == IDLE && start) cur_row <= '0;
            if (state == CHECK_ROW) cur_idx <= row_lo;              // Walk from row start
            if (state == NEXT_BLOCK) cur_idx <= cur_idx + 16'd1;
            if (state == NEXT_ROW && !last_row) cur_row <= cur_row + 16'd1;
        end
    end

    // Metadata captures, one cycle after each request
    always_ff @(posedge clk) begin
        if (state == ROW_HI) row_lo <= meta_rd_data[15:0];
        if (state == CHECK_ROW) row_hi <= meta_rd_data[15:0];
        if (state == COL_CAP) cur_col <= meta_rd_data[15:0];
    end

    // ==================================================
    // Outputs
    // ==================================================
    always_comb begin
        meta_req = '{en: 1'b0, kind: META_ROW_PTR, addr: '0};
        case (state)
            ROW_LO:  meta_req = '{en: 1'b1, kind: META_ROW_PTR, addr: cur_row};
            ROW_HI:  meta_req = '{en: 1'b1, kind: META_ROW_PTR, addr: cur_row + 16'd1};
            COL_REQ: meta_req = '{en: 1'b1, kind: META_COL_IDX, addr: cur_idx};
            default: ;
        endcase
    end

    assign load_start  = (state == COL_CAP);
    assign load_idx    = cur_idx;
    assign blk_valid   = (state == OFFER);
    assign blk_desc    = '{row: cur_row, col: cur_col, idx: cur_idx};  // Stable through OFFER
    assign blk_retired = (state == WAIT_DONE) && systolic_done;
    assign start_run   = (state == IDLE) && start;
    assign busy        = (state != IDLE) && (state != FINISH);  // Low while done pulses
    assign done        = (state == FINISH);

endmodule

// File: rtl/bsr_scheduler.sv
`timescale 1ns/1ps

module bsr_scheduler #(
    parameter int BLOCK_BYTES = 64                  // Bytes per block
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     cfg_write,
    input  bsr_pkg::geom_t           cfg_geom,
    // Metadata memory
    output bsr_pkg::meta_req_t       meta_req,
    input  logic [31:0]              meta_rd_data,
    // Block memory
    output logic                     block_rd_en,
    output bsr_pkg::byte_addr_t      block_rd_addr,
    input  bsr_pkg::byte_t           block_rd_data,
    // Systolic array
    output logic                     blk_valid,
    output bsr_pkg::blk_desc_t       blk_desc,
    output logic [BLOCK_BYTES*8-1:0] blk_data,
    input  logic                     systolic_ready,
    input  logic                     systolic_done,
    // Status
    output bsr_pkg::count_t          blocks_processed,
    output logic                     busy,
    output logic                     done
);
    import bsr_pkg::*;

    // ==================================================
    // Internal links
    // ==================================================
    geom_t      geom;           // Registered geometry for the walker
    logic       blk_retired;
    logic       start_run;
    logic       load_start;
    block_idx_t load_idx;
    logic       load_done;

    bsr_cfg_regs bsr_cfg_regs_inst (
        .clk, .rst_n, .cfg_write, .cfg_geom, .busy, .start_run, .blk_retired,
        .geom, .blocks_processed
    );

    bsr_row_walker bsr_row_walker_inst (
        .clk, .rst_n, .start, .geom, .meta_req, .meta_rd_data,
        .load_start, .load_idx, .load_done,
        .blk_valid, .blk_desc, .systolic_ready, .systolic_done,
        .blk_retired, .start_run, .busy, .done
    );

    // Buffer feeds blk_data directly, stable until the next load
    bsr_block_loader #(.BLOCK_BYTES(BLOCK_BYTES)) bsr_block_loader_inst (
        .clk, .rst_n, .load_start, .load_idx,
        .block_rd_en, .block_rd_addr, .block_rd_data,
        .load_done, .blk_data
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the BSR scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f bsr_scheduler.f \
    --top-module tb_bsr_scheduler \
    -o tb_bsr_scheduler

./obj_dir/tb_bsr_scheduler +verilator+error+limit+100 | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// File: verification/bsr_scheduler_assert.sv
`timescale 1ns/1ps

module bsr_scheduler_assert (
    input logic               clk,
    input logic               rst_n,
    input logic               blk_valid,
    input bsr_pkg::blk_desc_t blk_desc,
    input logic               systolic_ready,
    input logic               busy,
    input logic               done,
    input bsr_pkg::meta_req_t meta_req
);
    import bsr_pkg::*;

    int unsigned failures = 0;      // Summed into the testbench summary

    // ==================================================
    // Handshake properties
    // ==================================================
    // Offer stays up with the same descriptor until the array takes it
    valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        blk_valid && !systolic_ready |=> blk_valid && $stable(blk_desc))
    else begin
        $error("blk_valid dropped or blk_desc moved before systolic_ready");
        failures++;
    end

    // done is one cycle wide and busy is already low
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !busy ##1 !done)
    else begin
        $error("done not a single-cycle pulse with busy low");
        failures++;
    end

    meta_kind: assert property (@(posedge clk) disable iff (!rst_n)
        meta_req.en |-> meta_req.kind inside {META_ROW_PTR, META_COL_IDX})
    else begin
        $error("metadata request with undefined kind");
        failures++;
    end

endmodule

bind bsr_scheduler bsr_scheduler_assert bsr_scheduler_assert_inst (
    .clk, .rst_n, .blk_valid, .blk_desc, .systolic_ready, .busy, .done, .meta_req
);

// File: verification/bsr_tests.txt
// Hex word stream. First word is the test count, then per test
// num_rows num_cols, row_ptr[0..num_rows], col_idx[0..nnz-1]
5
// Middle row empty
4 4
0 2 3 3 5
0 3 1 0 2
// Empty first and last rows
5 3
0 0 2 3 4 4
1 2 0 2
// All rows empty
3 2
0 0 0 0
// Zero rows
0 4
0
// One dense row
1 6
0 6
0 1 2 3 4 5

// File: verification/tb_bsr_scheduler.sv
`timescale 1ns/1ps

module tb_bsr_scheduler;
    import bsr_pkg::*;

    localparam int BLOCK_BYTES  = 64;
    localparam int DATA_W       = BLOCK_BYTES * 8;
    localparam int DONE_TIMEOUT = 5000;         // Cycles allowed per layer

    logic              clk = 1'b0;
    logic              rst_n;
    logic              start;
    logic              cfg_write;
    geom_t             cfg_geom;
    meta_req_t         meta_req;
    logic [31:0]       meta_rd_data = '0;
    logic              block_rd_en;
    byte_addr_t        block_rd_addr;
    byte_t             block_rd_data = '0;
    logic              blk_valid;
    blk_desc_t         blk_desc;
    logic [DATA_W-1:0] blk_data;
    logic              systolic_ready = 1'b0;
    logic              systolic_done = 1'b0;
    count_t            blocks_processed;
    logic              busy;
    logic              done;

    logic [15:0] words [0:511];     // Raw test stream
    block_idx_t  rp [0:63];         // row_ptr of the current layer
    block_col_t  ci [0:255];        // col_idx of the current layer
    byte_t       bmem [0:4095];
    block_row_t  cur_rows;
    block_col_t  cur_cols;
    block_idx_t  cur_nnz;
    int          word_ptr;
    int          xfer_count = 0;    // Transfers seen in this run
    int          xfer_errors = 0;
    int          seq_errors = 0;
    int          timeouts = 0;
    int          ready_wait = -1;   // No offer pending
    int          done_wait = -1;    // No block in flight
    integer      fill_seed = 32'he6ac3a0c;
    integer      sys_seed = 32'he6ac3a0c;

    bsr_scheduler #(.BLOCK_BYTES(BLOCK_BYTES)) bsr_scheduler_inst (.*);

    always #2 clk = ~clk;

    // ==================================================
    // Memory and systolic models
    // ==================================================
    always @(posedge clk) begin
        if (meta_req.en) begin                  // One-cycle metadata latency
            if (meta_req.kind == META_ROW_PTR) meta_rd_data <= {16'd0, rp[meta_req.addr[5:0]]};
            else meta_rd_data <= {16'd0, ci[meta_req.addr[7:0]]};
        end
        if (block_rd_en) block_rd_data <= bmem[block_rd_addr[11:0]];
    end

    always @(posedge clk) begin
        systolic_done <= 1'b0;
        if (blk_valid && systolic_ready) begin
            systolic_ready <= 1'b0;             // Transfer at this edge
            ready_wait = -1;
            done_wait  = int'($unsigned($random(sys_seed)) % 5);
        end else if (done_wait == 0) begin
            systolic_done <= 1'b1;
            done_wait = -1;
        end else if (done_wait > 0) begin
            done_wait = done_wait - 1;
        end else if (blk_valid && !systolic_ready) begin
            if (ready_wait < 0) ready_wait = int'($unsigned($random(sys_seed)) % 4);
            if (ready_wait == 0) systolic_ready <= 1'b1;
            else ready_wait = ready_wait - 1;
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    task automatic compare_value(input string name, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] expected, inout int count);
        assert (got === expected) else begin
            $display("error at %0t ns: %s got %0h expected %0h", $time, name, got, expected);
            count++;
        end
    endtask

    // Row r holds idx when row_ptr[r] <= idx < row_ptr[r+1]
    function automatic block_row_t expected_row(input block_idx_t idx);
        block_row_t row = '1;
        for (int r = 0; r < int'(cur_rows); r++) begin
            if (rp[6'(r)] <= idx && idx < rp[6'(r + 1)]) row = 16'(r);
        end
        return row;
    endfunction

    function automatic logic [DATA_W-1:0] expected_block(input block_idx_t idx);
        logic [DATA_W-1:0] data;
        for (int k = 0; k < BLOCK_BYTES; k++) begin
            data[k*8 +: 8] = bmem[12'(int'(idx) * BLOCK_BYTES + k)];   // Byte 0 lowest
        end
        return data;
    endfunction

    task automatic check_transfer(input block_idx_t idx);
        compare_value("blk_desc.idx", DATA_W'(blk_desc.idx), DATA_W'(idx), xfer_errors);
        compare_value("blk_desc.row", DATA_W'(blk_desc.row), DATA_W'(expected_row(idx)),
                      xfer_errors);
        compare_value("blk_desc.col", DATA_W'(blk_desc.col), DATA_W'(ci[idx[7:0]]), xfer_errors);
        compare_value("blk_data", blk_data, expected_block(idx), xfer_errors);
    endtask

    always @(posedge clk) begin
        if (start && !busy && !done) xfer_count = 0;   // Run accepted at this edge
        if (blk_valid && systolic_ready) begin
            assert (xfer_count < int'(cur_nnz)) else begin
                $display("unexpected transfer at %0t ns beyond the %0d blocks of the layer",
                         $time, cur_nnz);
                xfer_errors++;
            end
            if (xfer_count < int'(cur_nnz)) check_transfer(16'(xfer_count));  // Index order
            xfer_count++;
        end
    end

    // ==================================================
    // Layer sequence
    // ==================================================
    task automatic run_layer(input int test_no);
        int cycles;
        cur_rows = words[9'(word_ptr)];
        cur_cols = words[9'(word_ptr + 1)];
        word_ptr = word_ptr + 2;
        for (int r = 0; r <= int'(cur_rows); r++) begin
            rp[6'(r)] = words[9'(word_ptr)];
            word_ptr++;
        end
        cur_nnz = rp[cur_rows[5:0]];
        for (int k = 0; k < int'(cur_nnz); k++) begin
            ci[8'(k)] = words[9'(word_ptr)];
            word_ptr++;
        end
        @(posedge clk);
        cfg_write <= 1'b1;                      // Geometry written while idle
        cfg_geom  <= '{num_rows: cur_rows, num_cols: cur_cols};
        @(posedge clk);
        cfg_write <= 1'b0;
        start     <= 1'b1;
        @(posedge clk);
        start     <= 1'b0;
        @(posedge clk);
        compare_value("busy", DATA_W'(busy), DATA_W'(1), seq_errors);
        compare_value("blocks_processed", DATA_W'(blocks_processed), '0, seq_errors);
        if (cur_rows > 16'd1 && cur_nnz > 16'd0) begin
            cycles = 0;
            while (blocks_processed == '0 && cycles < DONE_TIMEOUT) begin
                @(posedge clk);                 // Poke once the first block retired
                cycles++;
            end
            assert (blocks_processed != '0) else begin
                $display("timeout in test %0d, no block retired within %0d cycles",
                         test_no, DONE_TIMEOUT);
                timeouts++;
            end
            cfg_write <= 1'b1;                  // Both must be ignored mid-run
            cfg_geom  <= '{num_rows: 16'd1, num_cols: 16'd1};
            start     <= 1'b1;
            @(posedge clk);
            cfg_write <= 1'b0;
            start     <= 1'b0;
        end
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        assert (done) else begin
            $display("timeout in test %0d, no done within %0d cycles", test_no, DONE_TIMEOUT);
            timeouts++;
        end
        compare_value("transfer count", DATA_W'(xfer_count), DATA_W'(cur_nnz), seq_errors);
        compare_value("blocks_processed", DATA_W'(blocks_processed), DATA_W'(cur_nnz),
                      seq_errors);
    endtask

    initial begin
        int num_tests;
        int total;
        rst_n     = 1'b0;
        start     = 1'b0;
        cfg_write = 1'b0;
        cfg_geom  = '0;
        for (int a = 0; a < 4096; a++) begin
            bmem[12'(a)] = 8'($random(fill_seed));
        end
        $readmemh("verification/bsr_tests.txt", words);
        num_tests = int'(words[0]);
        word_ptr  = 1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // Idle outputs after reset
        compare_value("busy", DATA_W'(busy), '0, seq_errors);
        compare_value("done", DATA_W'(done), '0, seq_errors);
        compare_value("blk_valid", DATA_W'(blk_valid), '0, seq_errors);
        compare_value("meta_req.en", DATA_W'(meta_req.en), '0, seq_errors);
        compare_value("block_rd_en", DATA_W'(block_rd_en), '0, seq_errors);
        compare_value("blocks_processed", DATA_W'(blocks_processed), '0, seq_errors);
        for (int t = 0; t < num_tests && timeouts == 0; t++) begin
            run_layer(t);
        end
        total = xfer_errors + seq_errors + timeouts
              + int'(bsr_scheduler_inst.bsr_scheduler_assert_inst.failures);
        $display("Errors: %0d transfer, %0d sequence, %0d timeout, %0d assertion",
                 xfer_errors, seq_errors, timeouts,
                 bsr_scheduler_inst.bsr_scheduler_assert_inst.failures);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
